/* hdl/action_pkg.sv */
package action_pkg;

    // phv geometry
    localparam int NUM_CONTAINERS = 8;
    localparam int CONTAINER_W    = 32;
    localparam int IMM_W          = 16;
    localparam int SEL_W          = 3;

    typedef logic [CONTAINER_W-1:0] container_t;

    // container 0 sits in the low bits
    typedef container_t [NUM_CONTAINERS-1:0] phv_t;

    // codes 6 and 7 are unused and act as nop
    typedef enum logic [2:0] {
        OP_NOP      = 3'd0,
        OP_ADD      = 3'd1,
        OP_SUB      = 3'd2,
        OP_ADD_IMM  = 3'd3,
        OP_SET_IMM  = 3'd4,
        OP_LOAD_TBL = 3'd5
    } alu_op_e;

    // one action per container, 25 bits
    typedef struct packed {
        alu_op_e          op;
        logic [SEL_W-1:0] src_a;
        logic [SEL_W-1:0] src_b;
        logic [IMM_W-1:0] imm;
    } action_word_t;

    typedef action_word_t [NUM_CONTAINERS-1:0] action_vec_t;

    // operands and action handed from stage 1 to stage 2
    typedef struct packed {
        container_t   a;
        container_t   b;
        action_word_t action;
    } operand_t;

    typedef operand_t [NUM_CONTAINERS-1:0] operand_vec_t;

    // page table write request
    typedef struct packed {
        logic             en;
        logic [4:0]       addr;
        logic [IMM_W-1:0] data;
    } tbl_write_t;

endpackage

/* hdl/operand_crossbar.sv */
`timescale 1ns/1ps

module operand_crossbar (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      advance_i,

    input  action_pkg::phv_t          phv_i,
    input  action_pkg::action_vec_t   action_i,
    input  logic                      in_valid_i,

    output action_pkg::operand_vec_t  opnd_o,
    output logic                      valid_o
);

    import action_pkg::*;

    operand_vec_t opnd_d;
    logic         load_opnd;

    // per container operand selection
    always_comb begin
        for (int i = 0; i < NUM_CONTAINERS; i++) begin
            opnd_d[i].action = action_i[i];
            opnd_d[i].b      = phv_i[action_i[i].src_b];

            case (action_i[i].op)
                OP_ADD,
                OP_SUB,
                OP_ADD_IMM: begin
                    opnd_d[i].a = phv_i[action_i[i].src_a];
                end
                default: begin
                    // stage 2 passes the own value through
                    opnd_d[i].a = phv_i[i];
                end
            endcase
        end
    end

    // capture payload only for beats actually accepted
    assign load_opnd = advance_i && in_valid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_opnd) begin
            opnd_o <= opnd_d;
        end
    end

endmodule

/* hdl/page_table.sv */
`timescale 1ns/1ps

module page_table #(
    parameter int TBL_DEPTH = 32
) (
    input  logic                          clk,
    input  action_pkg::tbl_write_t        tbl_wr_i,
    input  logic                          advance_i,
    input  logic [action_pkg::IMM_W-1:0]  rd_imm_i,
    output logic [action_pkg::IMM_W-1:0]  entry_o
);

    import action_pkg::*;

    localparam int AW = (TBL_DEPTH > 1) ? $clog2(TBL_DEPTH) : 1;

    logic [IMM_W-1:0] mem [TBL_DEPTH];
    logic [AW-1:0]    wr_addr;
    logic [AW-1:0]    rd_addr;
    logic [IMM_W-1:0] entry_q;

    // only the low address bits index the table
    assign wr_addr = tbl_wr_i.addr[AW-1:0];
    assign rd_addr = rd_imm_i[AW-1:0];

    // write port runs regardless of the stall
    always_ff @(posedge clk) begin
        if (tbl_wr_i.en) begin
            mem[wr_addr] <= tbl_wr_i.data;
        end
    end

    // same-edge write is not visible here
    always_ff @(posedge clk) begin
        if (advance_i) begin
            entry_q <= mem[rd_addr];
        end
    end

    assign entry_o = entry_q;

endmodule

/* hdl/container_alu.sv */
`timescale 1ns/1ps

module container_alu #(
    parameter bit HAS_TBL = 1'b0
) (
    input  action_pkg::operand_t          opnd_i,
    input  logic [action_pkg::IMM_W-1:0]  tbl_entry_i,
    output action_pkg::container_t        result_o
);

    import action_pkg::*;

    container_t imm_ext;
    container_t tbl_ext;

    // zero extension of the 16-bit fields
    assign imm_ext = {{(CONTAINER_W-IMM_W){1'b0}}, opnd_i.action.imm};
    assign tbl_ext = {{(CONTAINER_W-IMM_W){1'b0}}, tbl_entry_i};

    // all arithmetic wraps at 32 bits
    always_comb begin
        case (opnd_i.action.op)
            OP_ADD: begin
                result_o = opnd_i.a + opnd_i.b;
            end
            OP_SUB: begin
                result_o = opnd_i.a - opnd_i.b;
            end
            OP_ADD_IMM: begin
                result_o = opnd_i.a + imm_ext;
            end
            OP_SET_IMM: begin
                result_o = imm_ext;
            end
            OP_LOAD_TBL: begin
                // only the table-attached container honors the load
                if (HAS_TBL) begin
                    result_o = tbl_ext;
                end else begin
                    result_o = opnd_i.a;
                end
            end
            default: begin
                // operand a already holds the container's own value
                result_o = opnd_i.a;
            end
        endcase
    end

endmodule

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          advance_i,

    input  action_pkg::operand_vec_t      opnd_i,
    input  logic                          valid_i,
    input  logic [action_pkg::IMM_W-1:0]  tbl_entry_i,

    output action_pkg::phv_t              phv_o,
    output logic                          valid_o
);

    import action_pkg::*;

    phv_t result;
    logic load_phv;

    // one alu per container with the table on the last one
    for (genvar i = 0; i < NUM_CONTAINERS; i++) begin : g_alu
        container_alu #(
            .HAS_TBL (i == NUM_CONTAINERS - 1)
        ) u_container_alu (
            .opnd_i      (opnd_i[i]),
            .tbl_entry_i (tbl_entry_i),
            .result_o    (result[i])
        );
    end

    // keep the previous phv across bubbles
    assign load_phv = advance_i && valid_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_o <= '0;
        end else if (load_phv) begin
            phv_o <= result;
        end
    end

endmodule

/* hdl/action_engine.sv */
`timescale 1ns/1ps

module action_engine #(
    parameter int TBL_DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // upstream beat
    input  action_pkg::phv_t         phv_i,
    input  action_pkg::action_vec_t  action_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,

    // page table write port
    input  action_pkg::tbl_write_t   tbl_wr_i,

    // downstream result
    output action_pkg::phv_t         phv_o,
    output logic                     phv_valid_o,
    input  logic                     out_ready_i
);

    import action_pkg::*;

    logic             advance;
    operand_vec_t     s1_opnd;
    logic             s1_valid;
    logic [IMM_W-1:0] tbl_entry;

    // the whole pipe moves when the output slot frees up
    assign advance    = !phv_valid_o || out_ready_i;
    assign in_ready_o = advance;

    operand_crossbar u_operand_crossbar (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance_i  (advance),
        .phv_i      (phv_i),
        .action_i   (action_i),
        .in_valid_i (in_valid_i),
        .opnd_o     (s1_opnd),
        .valid_o    (s1_valid)
    );

    // table lookup runs alongside stage 1
    page_table #(
        .TBL_DEPTH (TBL_DEPTH)
    ) u_page_table (
        .clk       (clk),
        .tbl_wr_i  (tbl_wr_i),
        .advance_i (advance),
        .rd_imm_i  (action_i[NUM_CONTAINERS-1].imm),
        .entry_o   (tbl_entry)
    );

    alu_stage u_alu_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance_i   (advance),
        .opnd_i      (s1_opnd),
        .valid_i     (s1_valid),
        .tbl_entry_i (tbl_entry),
        .phv_o       (phv_o),
        .valid_o     (phv_valid_o)
    );

endmodule

/* test/action_engine_checker.sv */
`timescale 1ns/1ps

module action_engine_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             in_ready_i,
    input logic             phv_valid_i,
    input logic             out_ready_i,
    input action_pkg::phv_t out_phv_i
);

    // output slot is empty out of reset
    valid_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> !phv_valid_i
    ) else $error("phv_valid_o high while reset is asserted");

    // stalled result must not move
    output_held_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        phv_valid_i && !out_ready_i |=> phv_valid_i && $stable(out_phv_i)
    ) else $error("phv_valid_o or phv_o changed while the output was stalled");

    // empty output slot means the pipe can move
    ready_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        !phv_valid_i |-> in_ready_i
    ) else $error("in_ready_o low although phv_valid_o is low");

endmodule

bind action_engine action_engine_checker u_action_engine_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_ready_i  (in_ready_o),
    .phv_valid_i (phv_valid_o),
    .out_ready_i (out_ready_i),
    .out_phv_i   (phv_o)
);

/* test/tb_action_engine.sv */
`timescale 1ns/1ps

module tb_action_engine;

    import action_pkg::*;

    localparam int TBL_DEPTH   = 32;
    localparam int BURST_LIMIT = 4000;
    localparam int DRAIN_LIMIT = 50;
    localparam int LAT_LIMIT   = 10;
    localparam int IDLE_TAIL   = 4;

    // opcode mixes for the stimulus phases
    localparam int MODE_REG = 0;
    localparam int MODE_IMM = 1;
    localparam int MODE_TBL = 2;
    localparam int MODE_ANY = 3;

    logic        clk;
    logic        rst_n;
    phv_t        phv_i;
    action_vec_t action_i;
    logic        in_valid_i;
    logic        in_ready_o;
    tbl_write_t  tbl_wr_i;
    phv_t        phv_o;
    logic        phv_valid_o;
    logic        out_ready_i;

    logic [31:0]      rng_state;
    logic [IMM_W-1:0] shadow_tbl [TBL_DEPTH];
    phv_t             expect_q [$];

    action_engine #(
        .TBL_DEPTH (TBL_DEPTH)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .phv_i       (phv_i),
        .action_i    (action_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .tbl_wr_i    (tbl_wr_i),
        .phv_o       (phv_o),
        .phv_valid_o (phv_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected output phv with the table as seen at the accepting edge
    function phv_t model_phv(input phv_t phv, input action_vec_t act);
        phv_t       result;
        container_t src_a;
        container_t src_b;
        container_t imm32;
        for (int i = 0; i < NUM_CONTAINERS; i++) begin
            src_a = phv[act[i].src_a];
            src_b = phv[act[i].src_b];
            imm32 = {16'h0000, act[i].imm};
            case (act[i].op)
                OP_ADD:     result[i] = src_a + src_b;
                OP_SUB:     result[i] = src_a - src_b;
                OP_ADD_IMM: result[i] = src_a + imm32;
                OP_SET_IMM: result[i] = imm32;
                OP_LOAD_TBL: begin
                    // only the last container owns the table
                    if (i == NUM_CONTAINERS - 1) begin
                        result[i] = {16'h0000, shadow_tbl[act[i].imm[4:0]]};
                    end else begin
                        result[i] = phv[i];
                    end
                end
                default:    result[i] = phv[i];
            endcase
        end
        return result;
    endfunction

    function alu_op_e pick_op(input int mode, input int idx);
        logic [31:0] r;
        alu_op_e     op;
        r = xorshift32();
        case (mode)
            MODE_REG: begin
                case (r % 3)
                    0:       op = OP_NOP;
                    1:       op = OP_ADD;
                    default: op = OP_SUB;
                endcase
            end
            MODE_IMM: begin
                // includes the two unused codes
                case (r % 5)
                    0:       op = OP_ADD_IMM;
                    1:       op = OP_SET_IMM;
                    2:       op = alu_op_e'(3'd6);
                    3:       op = alu_op_e'(3'd7);
                    default: op = OP_LOAD_TBL;
                endcase
            end
            MODE_TBL: begin
                if (idx == NUM_CONTAINERS - 1) begin
                    op = OP_LOAD_TBL;
                end else begin
                    op = alu_op_e'(r[2:0]);
                end
            end
            default: op = alu_op_e'(r[2:0]);
        endcase
        return op;
    endfunction

    task automatic make_beat(input int mode, output phv_t phv, output action_vec_t act);
        logic [31:0] r;
        for (int i = 0; i < NUM_CONTAINERS; i++) begin
            phv[i]       = xorshift32();
            r            = xorshift32();
            act[i].op    = pick_op(mode, i);
            act[i].src_a = r[2:0];
            act[i].src_b = r[5:3];
            act[i].imm   = r[31:16];
        end
    endtask

    function tbl_write_t make_write(input int pct);
        tbl_write_t  wr;
        logic [31:0] r;
        wr.en   = (xorshift32() % 100) < pct;
        r       = xorshift32();
        wr.addr = r[4:0];
        wr.data = r[31:16];
        return wr;
    endfunction

    task automatic check_value(input string what, input logic [255:0] got,
                               input logic [255:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s mismatch, got %h expected %h",
                     $time, what, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    // drive at the falling edge and judge the coming rising edge
    task automatic run_cycle(input logic vld, input phv_t phv, input action_vec_t act,
                             input logic ordy, input tbl_write_t wr,
                             output logic accepted, output logic transferred);
        phv_t expected;
        @(negedge clk);
        in_valid_i  = vld;
        phv_i       = phv;
        action_i    = act;
        out_ready_i = ordy;
        tbl_wr_i    = wr;
        #1;
        transferred = phv_valid_o && out_ready_i;
        accepted    = in_valid_i && in_ready_o;
        if (transferred) begin
            if (expect_q.size() == 0) begin
                report_failure("output beat appeared without any accepted input beat");
            end else begin
                expected = expect_q.pop_front();
                check_value("output phv", phv_o, expected);
            end
        end
        // lookup sees the table before this edge's write
        if (accepted) begin
            expect_q.push_back(model_phv(phv, act));
        end
        if (wr.en) begin
            shadow_tbl[wr.addr] = wr.data;
        end
    endtask

    task automatic fill_table();
        tbl_write_t  wr;
        logic [31:0] r;
        logic        accepted;
        logic        transferred;
        for (int a = 0; a < TBL_DEPTH; a++) begin
            r       = xorshift32();
            wr.en   = 1'b1;
            wr.addr = 5'(a);
            wr.data = r[15:0];
            run_cycle(1'b0, '0, '0, 1'b1, wr, accepted, transferred);
        end
    endtask

    task automatic run_burst(input int mode, input int beats, input int gap_pct,
                             input int ready_pct, input int wr_pct);
        phv_t        phv;
        action_vec_t act;
        tbl_write_t  wr;
        logic        vld;
        logic        ordy;
        logic        accepted;
        logic        transferred;
        int          done;
        int          cycles;
        done   = 0;
        cycles = 0;
        while (done < beats && cycles < BURST_LIMIT) begin
            make_beat(mode, phv, act);
            vld  = (xorshift32() % 100) >= gap_pct;
            ordy = (xorshift32() % 100) < ready_pct;
            wr   = make_write(wr_pct);
            run_cycle(vld, phv, act, ordy, wr, accepted, transferred);
            if (accepted) begin
                done++;
            end
            cycles++;
        end
        if (done < beats) begin
            report_failure("input burst was not fully accepted within its cycle limit");
        end
    endtask

    task automatic drain_pipeline();
        logic accepted;
        logic transferred;
        int   cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0, '0, '0, 1'b1, '0, accepted, transferred);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            report_failure("pipeline did not drain its pending beats within the cycle limit");
        end
    endtask

    // a repeated or stray beat would surface in these idle cycles
    task automatic watch_idle(input int cycles);
        logic accepted;
        logic transferred;
        for (int c = 0; c < cycles; c++) begin
            run_cycle(1'b0, '0, '0, 1'b1, '0, accepted, transferred);
        end
    endtask

    // two register stages, so a lone beat is on the bus two cycles after it is driven
    task automatic check_latency();
        phv_t        phv;
        action_vec_t act;
        logic        accepted;
        logic        transferred;
        int          cycles;
        make_beat(MODE_ANY, phv, act);
        run_cycle(1'b1, phv, act, 1'b1, '0, accepted, transferred);
        check_value("single beat acceptance", 256'(accepted), 256'(1'b1));
        cycles      = 0;
        transferred = 1'b0;
        while (!transferred && cycles < LAT_LIMIT) begin
            run_cycle(1'b0, '0, '0, 1'b1, '0, accepted, transferred);
            cycles++;
        end
        if (!transferred) begin
            report_failure("single beat never reached the output within the cycle limit");
        end
        check_value("single beat latency in cycles", 256'(cycles), 256'(2));
    endtask

    initial begin
        rng_state   = 32'd75;
        rst_n       = 1'b0;
        in_valid_i  = 1'b0;
        phv_i       = '0;
        action_i    = '0;
        tbl_wr_i    = '0;
        out_ready_i = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;

        check_value("phv_valid_o after reset", 256'(phv_valid_o), 256'(1'b0));
        check_value("in_ready_o after reset", 256'(in_ready_o), 256'(1'b1));
        check_value("phv_o after reset", phv_o, '0);

        fill_table();
        run_burst(MODE_REG, 200, 0, 100, 0);
        run_burst(MODE_IMM, 200, 0, 100, 0);
        run_burst(MODE_TBL, 200, 10, 100, 40);
        // back-pressure and input gaps
        run_burst(MODE_ANY, 400, 30, 50, 20);
        drain_pipeline();
        check_latency();
        watch_idle(IDLE_TAIL);

        if (expect_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "beats left in the scoreboard at the end of the run");
        end
    end

endmodule

/* project.f */
hdl/action_pkg.sv
hdl/operand_crossbar.sv
hdl/page_table.sv
hdl/container_alu.sv
hdl/alu_stage.sv
hdl/action_engine.sv
test/action_engine_checker.sv
test/tb_action_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the action engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_action_engine -f project.f \
    || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_action_engine 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qF -- '*** PASSED ***' \
    && echo "simulation run ok" \
    || { echo "simulation run reported failure"; exit 1; }
